// File: tb.f
+incdir+include
hw/fetch_pkg.sv
hw/fetch_group_if.sv
hw/pc_gen.sv
hw/early_imm_decoder.sv
hw/branch_predictor.sv
hw/predecode_stage.sv
hw/multi_fetch.sv
bench/tb_multi_fetch.sv

// File: Makefile
TOOL   = verilator
FLAGS  = --timing -j 0
TOP    = tb_multi_fetch
FLIST  = tb.f
BUILD  = obj_dir
LOG    = sim.log
PASS   = TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: bench/tb_multi_fetch.sv
`timescale 1ns/10ps

`include "fetch_cfg.svh"

module tb_multi_fetch;

   localparam fetch_pkg::inst_t NOP = 32'h0000_0013;     // addi x0, x0, 0
   localparam int TEST_COUNT = 6;
   localparam int MAX_CYCLES = TEST_COUNT * 40 + 160;   // About 40 cycles per test plus margin

   logic                     clk = 1'b0;
   logic                     rst_i;
   logic                     fetch_ready_i;
   logic                     update_valid_i;
   fetch_pkg::addr_t         update_pc_i;
   logic                     update_taken_i;
   logic                     mispredict_i;
   fetch_pkg::addr_t         correct_pc_i;
   fetch_pkg::addr_t         inst_addr_o   [`FETCH_WIDTH];
   fetch_pkg::inst_t         instruction_i [`FETCH_WIDTH];
   logic [`FETCH_WIDTH-1:0]  fetch_valid_o;
   fetch_pkg::addr_t         pc_o          [`FETCH_WIDTH];
   fetch_pkg::inst_t         instruction_o [`FETCH_WIDTH];
   fetch_pkg::addr_t         imm_o         [`FETCH_WIDTH];
   logic [`FETCH_WIDTH-1:0]  branch_prediction_o;

   fetch_pkg::inst_t   mem [fetch_pkg::addr_t];           // Sparse instruction memory
   fetch_pkg::bp_ctr_t ref_ctr [1 << `BP_INDEX_BITS];     // Reference counter table
   fetch_pkg::addr_t   fill_imm [16];                     // Filler immediates of test 1
   int cycle_cnt = 0;
   int check_cnt = 0;
   int err_cnt   = 0;

   multi_fetch u_dut (.*);

   always #2 clk = ~clk;   // 4 ns period

   // Run limit
   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > MAX_CYCLES) begin
         $display("Timeout after %0d cycles, tests did not finish", MAX_CYCLES);
         $display("TB FAILED");
         $finish;
      end
   end

   // ==============================
   // Memory model and helpers
   // ==============================
   function automatic fetch_pkg::inst_t read_mem(fetch_pkg::addr_t a);
      if (mem.exists(a)) return mem[a];
      return NOP;                          // Unwritten space reads as NOP
   endfunction

   // Same-cycle data for every slot
   always_comb begin
      for (int k = 0; k < `FETCH_WIDTH; k++) begin
         instruction_i[k] = read_mem(inst_addr_o[k]);
      end
   end

   function automatic fetch_pkg::inst_t enc_branch(fetch_pkg::addr_t off);
      return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], 7'b1100011};   // beq
   endfunction

   function automatic fetch_pkg::inst_t enc_jal(fetch_pkg::addr_t off);
      return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
   endfunction

   function automatic fetch_pkg::inst_t enc_itype(logic [11:0] imm, logic [6:0] opc);
      return {imm, 5'd1, 3'b000, 5'd1, opc};
   endfunction

   // Saturating 2-bit rule, index from pc[7:2]
   function automatic void ref_update(fetch_pkg::addr_t pc, logic taken);
      logic [`BP_INDEX_BITS-1:0] idx;
      idx = pc[`BP_INDEX_BITS+1:2];
      if (taken && ref_ctr[idx] != 2'd3) begin
         ref_ctr[idx] = ref_ctr[idx] + 2'd1;
      end else if (!taken && ref_ctr[idx] != 2'd0) begin
         ref_ctr[idx] = ref_ctr[idx] - 2'd1;
      end
   endfunction

   function automatic logic ref_taken(fetch_pkg::addr_t pc);
      return ref_ctr[pc[`BP_INDEX_BITS+1:2]][1];
   endfunction

   task automatic check(string name, logic [31:0] got, logic [31:0] exp);
      check_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic report_test(string name, int first_err);
      if (err_cnt == first_err) $display("Test %s: ok", name);
      else $display("Test %s: %0d errors", name, err_cnt - first_err);
   endtask

   // One clock, ends on the falling edge where inputs change
   task automatic step();
      @(posedge clk);
      @(negedge clk);
   endtask

   // Mispredict pulse, also updates the counter at the target as not taken
   task automatic redirect_to(fetch_pkg::addr_t target);
      mispredict_i   = 1'b1;
      update_valid_i = 1'b1;
      update_pc_i    = target;
      update_taken_i = 1'b0;
      correct_pc_i   = target;
      ref_update(target, 1'b0);
      step();
      mispredict_i   = 1'b0;
      update_valid_i = 1'b0;
   endtask

   task automatic train_taken(fetch_pkg::addr_t pc);
      update_valid_i = 1'b1;
      update_pc_i    = pc;
      update_taken_i = 1'b1;
      ref_update(pc, 1'b1);
      step();
      update_valid_i = 1'b0;
   endtask

   // ==============================
   // Tests
   // ==============================
   task automatic test_sequential();
      int               first_err;
      logic [11:0]      r;
      fetch_pkg::addr_t a;
      first_err = err_cnt;
      for (int i = 0; i < 16; i++) begin
         r = 12'($urandom);
         fill_imm[i] = {{20{r[11]}}, r};
         mem[`RESET_PC + 32'(4 * i)] = enc_itype(r, 7'b0010011);   // addi filler
      end
      repeat (8) step();                   // Reset held from time 0
      check("fetch_valid_o", 32'(fetch_valid_o), 32'h0);
      check("inst_addr_o[0]", inst_addr_o[0], `RESET_PC);
      rst_i = 1'b0;
      for (int g = 0; g < 4; g++) begin
         step();
         check("fetch_valid_o", 32'(fetch_valid_o), 32'hF);
         for (int k = 0; k < `FETCH_WIDTH; k++) begin
            a = `RESET_PC + 32'(16 * g + 4 * k);
            check("pc_o", pc_o[k], a);
            check("instruction_o", instruction_o[k], read_mem(a));
            check("imm_o", imm_o[k], fill_imm[4 * g + k]);
         end
      end
      report_test("sequential", first_err);
   endtask

   task automatic test_jal();
      int               first_err;
      fetch_pkg::addr_t off;
      fetch_pkg::addr_t base;
      first_err = err_cnt;
      base = 32'h0000_2000;
      off  = (($urandom & 32'h3FF) << 2) + 32'd64;   // Even, forward
      mem[base + 32'd4] = enc_jal(off);
      redirect_to(base);
      step();
      check("fetch_valid_o", 32'(fetch_valid_o), 32'h3);
      check("branch_prediction_o", 32'(branch_prediction_o), 32'h2);
      check("inst_addr_o[0]", inst_addr_o[0], base + 32'd4 + off);
      step();
      check("pc_o[0]", pc_o[0], base + 32'd4 + off);
      report_test("jal", first_err);
   endtask

   task automatic test_branch_training();
      int               first_err;
      fetch_pkg::addr_t base;
      fetch_pkg::addr_t br_pc;
      fetch_pkg::addr_t off;
      first_err = err_cnt;
      base  = 32'h0000_3000;
      br_pc = base + 32'd8;                // Slot 2
      off   = 32'hFFFF_FFE8;               // -24
      mem[br_pc] = enc_branch(off);
      redirect_to(base);
      step();
      check("fetch_valid_o", 32'(fetch_valid_o), ref_taken(br_pc) ? 32'h7 : 32'hF);
      train_taken(br_pc);
      train_taken(br_pc);
      redirect_to(base);
      step();
      check("fetch_valid_o", 32'(fetch_valid_o), ref_taken(br_pc) ? 32'h7 : 32'hF);
      check("branch_prediction_o", 32'(branch_prediction_o), ref_taken(br_pc) ? 32'h4 : 32'h0);
      step();
      check("pc_o[0]", pc_o[0], br_pc + off);
      report_test("branch_training", first_err);
   endtask

   task automatic test_imm_decode();
      int               first_err;
      fetch_pkg::addr_t base;
      first_err = err_cnt;
      base = 32'h0000_4000;
      mem[base]          = enc_branch(32'hFFFF_FF00);          // -256, counter not taken
      mem[base + 32'd4]  = enc_itype(12'hFFB, 7'b1100111);     // jalr -5
      mem[base + 32'd8]  = enc_itype(12'h7FF, 7'b0010011);     // addi 2047
      mem[base + 32'd12] = enc_jal(32'hFFF0_0000);             // Most negative J offset
      redirect_to(base);
      step();
      check("fetch_valid_o", 32'(fetch_valid_o), 32'hF);
      check("branch_prediction_o", 32'(branch_prediction_o), 32'h8);
      check("imm_o[0]", imm_o[0], 32'hFFFF_FF00);
      check("imm_o[1]", imm_o[1], 32'hFFFF_FFFB);
      check("imm_o[2]", imm_o[2], 32'h0000_07FF);
      check("imm_o[3]", imm_o[3], 32'hFFF0_0000);
      report_test("imm_decode", first_err);
   endtask

   task automatic test_flush();
      int               first_err;
      fetch_pkg::addr_t base;
      first_err = err_cnt;
      base = 32'h0000_5000;
      step();
      check("fetch_valid_o", 32'(fetch_valid_o), 32'hF);   // Full group before the pulse
      redirect_to(base);
      check("fetch_valid_o", 32'(fetch_valid_o), 32'h0);
      check("inst_addr_o[0]", inst_addr_o[0], base);
      step();
      check("fetch_valid_o", 32'(fetch_valid_o), 32'hF);
      check("pc_o[0]", pc_o[0], base);
      check("pc_o[3]", pc_o[3], base + 32'd12);
      report_test("flush", first_err);
   endtask

   task automatic test_backpressure();
      int               first_err;
      fetch_pkg::addr_t base;
      first_err = err_cnt;
      base = 32'h0000_6000;
      for (int k = 0; k < 8; k++) begin
         mem[base + 32'(4 * k)] = enc_itype(12'($urandom), 7'b0010011);
      end
      redirect_to(base);
      step();
      fetch_ready_i = 1'b0;
      repeat (3) begin
         step();
         check("inst_addr_o[0]", inst_addr_o[0], base + 32'd16);
         check("pc_o[0]", pc_o[0], base);
         check("fetch_valid_o", 32'(fetch_valid_o), 32'hF);
         check("instruction_o[3]", instruction_o[3], read_mem(base + 32'd12));
      end
      fetch_ready_i = 1'b1;
      step();
      check("pc_o[0]", pc_o[0], base + 32'd16);
      check("inst_addr_o[0]", inst_addr_o[0], base + 32'd32);
      report_test("backpressure", first_err);
   endtask

   // ==============================
   // Sequence
   // ==============================
   initial begin
      rst_i          = 1'b1;
      fetch_ready_i  = 1'b1;
      update_valid_i = 1'b0;
      update_pc_i    = '0;
      update_taken_i = 1'b0;
      mispredict_i   = 1'b0;
      correct_pc_i   = '0;
      void'($urandom(32'h4082));
      for (int i = 0; i < (1 << `BP_INDEX_BITS); i++) begin
         ref_ctr[i] = 2'd1;                // Weakly not taken
      end
      test_sequential();
      test_jal();
      test_branch_training();
      test_imm_decode();
      test_flush();
      test_backpressure();
      $display("Tests %0d, checks %0d, errors %0d", TEST_COUNT, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// File: hw/multi_fetch.sv
`timescale 1ns/10ps

`include "fetch_cfg.svh"

module multi_fetch (
   input  logic                     clk,
   input  logic                     rst_i,
   input  logic                     fetch_ready_i,   // Instruction buffer can accept

   // Instruction memory, data returns in the same cycle
   output fetch_pkg::addr_t         inst_addr_o   [`FETCH_WIDTH],
   input  fetch_pkg::inst_t         instruction_i [`FETCH_WIDTH],

   // ==============================
   // Resolution port from back end
   // ==============================
   input  logic                     update_valid_i,
   input  fetch_pkg::addr_t         update_pc_i,
   input  logic                     update_taken_i,
   input  logic                     mispredict_i,    // Always paired with update_valid_i
   input  fetch_pkg::addr_t         correct_pc_i,

   // ==============================
   // Fetched group
   // ==============================
   output logic [`FETCH_WIDTH-1:0]  fetch_valid_o,
   output fetch_pkg::addr_t         pc_o          [`FETCH_WIDTH],
   output fetch_pkg::inst_t         instruction_o [`FETCH_WIDTH],
   output fetch_pkg::addr_t         imm_o         [`FETCH_WIDTH],
   output logic [`FETCH_WIDTH-1:0]  branch_prediction_o
);

   logic             redirect;      // Predicted taken, back to pc_gen
   fetch_pkg::addr_t redirect_pc;

   fetch_group_if grp ();

   // Memory hookup through the group interface
   assign inst_addr_o = grp.pc;
   assign grp.inst    = instruction_i;

   pc_gen u_pc_gen (
      .clk           (clk),
      .rst_i         (rst_i),
      .fetch_ready_i (fetch_ready_i),
      .mispredict_i  (mispredict_i),
      .correct_pc_i  (correct_pc_i),
      .redirect_i    (redirect),
      .redirect_pc_i (redirect_pc),
      .grp           (grp.gen)
   );

   predecode_stage u_predecode (
      .clk            (clk),
      .rst_i          (rst_i),
      .grp            (grp.dec),
      .redirect_o     (redirect),
      .redirect_pc_o  (redirect_pc),
      .valid_o        (fetch_valid_o),
      .pc_o           (pc_o),
      .inst_o         (instruction_o),
      .imm_o          (imm_o),
      .pred_taken_o   (branch_prediction_o),
      .update_valid_i (update_valid_i),
      .update_pc_i    (update_pc_i),
      .update_taken_i (update_taken_i)
   );

endmodule

// File: hw/predecode_stage.sv
`timescale 1ns/10ps

`include "fetch_cfg.svh"

module predecode_stage (
   input  logic                     clk,
   input  logic                     rst_i,
   fetch_group_if.dec               grp,
   output logic                     redirect_o,                  // Level, to pc_gen
   output fetch_pkg::addr_t         redirect_pc_o,
   output logic [`FETCH_WIDTH-1:0]  valid_o,
   output fetch_pkg::addr_t         pc_o   [`FETCH_WIDTH],
   output fetch_pkg::inst_t         inst_o [`FETCH_WIDTH],
   output fetch_pkg::addr_t         imm_o  [`FETCH_WIDTH],
   output logic [`FETCH_WIDTH-1:0]  pred_taken_o,
   input  logic                     update_valid_i,
   input  fetch_pkg::addr_t         update_pc_i,
   input  logic                     update_taken_i
);

   fetch_pkg::addr_t         slot_imm  [`FETCH_WIDTH];
   fetch_pkg::ctrl_kind_e    slot_kind [`FETCH_WIDTH];
   logic [`FETCH_WIDTH-1:0]  bp_taken;       // Raw counter MSB per slot
   logic [`FETCH_WIDTH-1:0]  slot_taken;     // Slot redirects fetch
   logic [`FETCH_WIDTH-1:0]  keep;           // Slots up to first taken
   logic                     any_taken;
   fetch_pkg::addr_t         target;

   // ==============================
   // Per-slot decode and prediction
   // ==============================
   for (genvar k = 0; k < `FETCH_WIDTH; k++) begin : g_dec
      early_imm_decoder u_imm_dec (
         .inst_i (grp.inst[k]),
         .imm_o  (slot_imm[k]),
         .kind_o (slot_kind[k])
      );

      // JAL always, branch only if the counter says so, JALR never
      assign slot_taken[k] = (slot_kind[k] == fetch_pkg::KIND_JAL) |
                             ((slot_kind[k] == fetch_pkg::KIND_BRANCH) & bp_taken[k]);
   end

   branch_predictor u_bp (
      .clk            (clk),
      .rst_i          (rst_i),
      .lookup_pc_i    (grp.pc),
      .taken_o        (bp_taken),
      .update_valid_i (update_valid_i),
      .update_pc_i    (update_pc_i),
      .update_taken_i (update_taken_i)
   );

   // First taken slot picks the target, later slots drop out
   always_comb begin
      any_taken = 1'b0;
      target    = '0;
      keep      = '0;
      for (int k = 0; k < `FETCH_WIDTH; k++) begin
         keep[k] = ~any_taken;
         if (!any_taken && slot_taken[k]) begin
            any_taken = 1'b1;
            target    = grp.pc[k] + slot_imm[k];   // PC relative for both B and J
         end
      end
   end

   // No redirect while held or while the back end is correcting
   assign redirect_o    = any_taken & ~grp.stall & ~grp.flush;
   assign redirect_pc_o = target;

   // ==============================
   // Output register
   // ==============================
   always_ff @(posedge clk) begin
      if (rst_i || grp.flush) begin
         valid_o      <= '0;
         pred_taken_o <= '0;
      end else if (!grp.stall) begin
         valid_o      <= keep;
         pred_taken_o <= slot_taken & keep;     // Only the first taken slot survives
      end
   end

   // Payload, follows the valid bits
   always_ff @(posedge clk) begin
      if (!grp.stall) begin
         pc_o   <= grp.pc;
         inst_o <= grp.inst;
         imm_o  <= slot_imm;
      end
   end

endmodule

// File: hw/branch_predictor.sv
`timescale 1ns/10ps

`include "fetch_cfg.svh"

module branch_predictor (
   input  logic                     clk,
   input  logic                     rst_i,
   input  fetch_pkg::addr_t         lookup_pc_i [`FETCH_WIDTH],   // One per slot
   output logic [`FETCH_WIDTH-1:0]  taken_o,
   input  logic                     update_valid_i,
   input  fetch_pkg::addr_t         update_pc_i,
   input  logic                     update_taken_i
);

   localparam int BP_ENTRIES = 1 << `BP_INDEX_BITS;

   fetch_pkg::bp_ctr_t         table_q [BP_ENTRIES];
   logic [`BP_INDEX_BITS-1:0]  upd_idx;
   fetch_pkg::bp_ctr_t         upd_ctr;

   // ==============================
   // Lookup, combinational
   // ==============================
   for (genvar k = 0; k < `FETCH_WIDTH; k++) begin : g_read
      // Word aligned PC, drop bits [1:0]
      assign taken_o[k] = table_q[lookup_pc_i[k][`BP_INDEX_BITS+1:2]][1];
   end

   // ==============================
   // Update, one per cycle
   // ==============================
   assign upd_idx = update_pc_i[`BP_INDEX_BITS+1:2];
   assign upd_ctr = table_q[upd_idx];

   always_ff @(posedge clk) begin
      if (rst_i) begin
         // All entries start weakly not taken
         for (int i = 0; i < BP_ENTRIES; i++) begin
            table_q[i] <= fetch_pkg::CTR_RESET;
         end
      end else if (update_valid_i) begin
         if (update_taken_i) begin
            if (upd_ctr != 2'd3) begin
               table_q[upd_idx] <= upd_ctr + 2'd1;   // Saturate at strongly taken
            end
         end else begin
            if (upd_ctr != 2'd0) begin
               table_q[upd_idx] <= upd_ctr - 2'd1;   // Saturate at strongly not taken
            end
         end
      end
   end

endmodule

// File: hw/early_imm_decoder.sv
`timescale 1ns/10ps

module early_imm_decoder (
   input  fetch_pkg::inst_t      inst_i,
   output fetch_pkg::addr_t      imm_o,    // Sign-extended immediate
   output fetch_pkg::ctrl_kind_e kind_o
);

   fetch_pkg::addr_t imm_b;
   fetch_pkg::addr_t imm_j;
   fetch_pkg::addr_t imm_i;

   // B format, 13-bit even offset
   assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

   // J format, 21-bit even offset
   assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                   inst_i[30:21], 1'b0};

   // I format, also the default for non control-flow opcodes
   assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};

   always_comb begin
      case (inst_i[6:0])
         fetch_pkg::OPC_BRANCH: begin
            kind_o = fetch_pkg::KIND_BRANCH;
            imm_o  = imm_b;
         end
         fetch_pkg::OPC_JAL: begin
            kind_o = fetch_pkg::KIND_JAL;
            imm_o  = imm_j;
         end
         fetch_pkg::OPC_JALR: begin
            kind_o = fetch_pkg::KIND_JALR;
            imm_o  = imm_i;                     // Offset from rs1, no target here
         end
         default: begin
            kind_o = fetch_pkg::KIND_NONE;
            imm_o  = imm_i;
         end
      endcase
   end

endmodule

// File: hw/pc_gen.sv
`timescale 1ns/10ps

`include "fetch_cfg.svh"

module pc_gen (
   input  logic             clk,
   input  logic             rst_i,
   input  logic             fetch_ready_i,   // Level, low holds the PC
   input  logic             mispredict_i,    // Pulse from the resolution port
   input  fetch_pkg::addr_t correct_pc_i,
   input  logic             redirect_i,      // Predicted taken in the current group
   input  fetch_pkg::addr_t redirect_pc_i,
   fetch_group_if.gen       grp
);

   // Sequential step between groups
   localparam fetch_pkg::addr_t GROUP_BYTES = 4 * `FETCH_WIDTH;

   fetch_pkg::addr_t base_q;   // Address of slot 0
   fetch_pkg::addr_t base_d;

   // ==============================
   // Next base PC
   // ==============================
   always_comb begin
      if (mispredict_i) begin
         base_d = correct_pc_i;                 // Back end wins, even under stall
      end else if (!fetch_ready_i) begin
         base_d = base_q;                       // Hold
      end else if (redirect_i) begin
         base_d = redirect_pc_i;                // Follow the predicted target
      end else begin
         base_d = base_q + GROUP_BYTES;         // Fall through to next group
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         base_q <= `RESET_PC;
      end else begin
         base_q <= base_d;
      end
   end

   // Slot addresses
   for (genvar k = 0; k < `FETCH_WIDTH; k++) begin : g_slot_pc
      assign grp.pc[k] = base_q + fetch_pkg::addr_t'(4 * k);
   end

   // Stage control seen by the decode side
   assign grp.stall = ~fetch_ready_i;
   assign grp.flush = mispredict_i;

endmodule

// File: hw/fetch_group_if.sv
`timescale 1ns/10ps

`include "fetch_cfg.svh"

// One fetch group between the PC stage and the predecode stage
interface fetch_group_if;

   fetch_pkg::addr_t pc   [`FETCH_WIDTH];   // Slot addresses, base + 4*k
   fetch_pkg::inst_t inst [`FETCH_WIDTH];   // Memory data for those addresses
   logic             stall;                 // Back end not ready, hold everything
   logic             flush;                 // Mispredict seen this cycle

   // PC side drives addresses and control, memory data comes in beside it
   modport gen (
      output pc,
      output stall,
      output flush,
      input  inst
   );

   // Decode side only observes
   modport dec (
      input pc,
      input inst,
      input stall,
      input flush
   );

endinterface

// File: hw/fetch_pkg.sv
package fetch_pkg;

   // ==============================
   // Basic words
   // ==============================
   typedef logic [31:0] addr_t;   // Byte address
   typedef logic [31:0] inst_t;   // Raw 32-bit instruction

   // Control-flow class seen by the front end
   typedef enum logic [1:0] {
      KIND_NONE   = 2'd0,
      KIND_BRANCH = 2'd1,          // Conditional, goes through the predictor
      KIND_JAL    = 2'd2,          // Always taken
      KIND_JALR   = 2'd3           // Target unknown here, fetched as not taken
   } ctrl_kind_e;

   // 2-bit saturating counter, MSB set means predict taken
   typedef logic [1:0] bp_ctr_t;

   // Weakly not taken
   localparam bp_ctr_t CTR_RESET = 2'd1;

   // ==============================
   // RV32I major opcodes
   // ==============================
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_JALR   = 7'b1100111;

endpackage

// File: include/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// ==============================
// Fetch front end configuration
// ==============================

// Instructions fetched per group
`define FETCH_WIDTH 4

// First fetch address out of reset
`define RESET_PC 32'h0000_1000

// Predictor table is 2**BP_INDEX_BITS entries, indexed from pc[BP_INDEX_BITS+1:2]
`define BP_INDEX_BITS 6

`endif
